// File: common/comms_params.svh
`ifndef COMMS_PARAMS_SVH
`define COMMS_PARAMS_SVH

// clocks per serial bit, kept small for simulation
`define COMMS_BIT_CYCLES 8

// one packet on the wire
`define COMMS_WORD_BITS 32

// board geometry
`define COMMS_GRID_COLS 8
`define COMMS_GRID_ROWS 13

// words that follow a board start packet: rows, points, one spare
`define COMMS_FRAME_WORDS 15

`define COMMS_POINT_BITS 10

`endif

// File: common/comms_pkg.sv
`default_nettype none

`include "comms_params.svh"

package comms_pkg;

    typedef enum logic [2:0] {
        PKT_PLAYER      = 3'b000,
        PKT_BOARD_START = 3'b001,
        PKT_ACK         = 3'b111
    } pkt_type_e;

    // same order as bits 29:6 of a player packet
    typedef struct packed {
        logic [1:0] dir;
        logic [8:0] loc_x;
        logic [8:0] loc_y;
        logic [3:0] state;
    } player_rec_t;

    typedef logic [3:0] cell_t; // object code

    // ascending range puts column 0 in the top nibble
    typedef cell_t [0:`COMMS_GRID_COLS-1] row_t;
    typedef row_t [`COMMS_GRID_ROWS-1:0] board_t;

    // player packet field offsets
    localparam int SLOT_LSB = 30; // 2 bits
    localparam int REC_LSB  = 6;  // player_rec_t, 24 bits
    localparam int GAME_LSB = 3;  // 3 bits
    localparam int TYPE_LSB = 0;  // pkt_type_e

endpackage

`default_nettype wire

// File: link/serial_rx.sv
`default_nettype none

`include "comms_params.svh"

module serial_rx (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        line_in,
    output logic      [`COMMS_WORD_BITS-1:0] rx_word,
    output logic                             rx_valid
);
    localparam int CNT_W = $clog2(`COMMS_BIT_CYCLES);
    localparam int BIT_W = $clog2(`COMMS_WORD_BITS);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`COMMS_BIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(`COMMS_BIT_CYCLES / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e                   state;
    logic                        line_meta, line_sync, line_prev;
    logic [CNT_W-1:0]            cycle_cnt;
    logic [BIT_W-1:0]            bit_cnt;
    logic [`COMMS_WORD_BITS-1:0] shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_meta <= 1'b1; // idle line is high
            line_sync <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            line_meta <= line_in;
            line_sync <= line_meta;
            line_prev <= line_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_IDLE;
            cycle_cnt <= '0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cycle_cnt <= '0;
                    if (line_prev && !line_sync) state <= RX_START; // falling edge
                end
                RX_START: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == HALF) begin
                        cycle_cnt <= '0;
                        bit_cnt   <= '0;
                        state     <= line_sync ? RX_IDLE : RX_DATA; // glitch if high again
                    end
                end
                RX_DATA: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == LAST) begin
                        shift   <= {line_sync, shift[`COMMS_WORD_BITS-1:1]}; // lsb first
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(`COMMS_WORD_BITS - 1)) state <= RX_STOP;
                    end
                end
                default: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == LAST) begin
                        if (line_sync) begin
                            rx_word  <= shift;
                            rx_valid <= 1'b1;
                        end
                        state <= RX_IDLE; // bad stop bit drops the frame
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: link/serial_tx.sv
`default_nettype none

`include "comms_params.svh"

module serial_tx (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        tx_req,
    input  wire logic [`COMMS_WORD_BITS-1:0] tx_word,
    output logic                             line_out,
    output logic                             tx_ack
);
    localparam int FRAME_BITS = `COMMS_WORD_BITS + 2;
    localparam int CNT_W      = $clog2(`COMMS_BIT_CYCLES);
    localparam int BIT_W      = $clog2(FRAME_BITS);

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_DONE} tx_state_e;

    tx_state_e             state;
    logic [FRAME_BITS-1:0] shift;
    logic [CNT_W-1:0]      cycle_cnt;
    logic [BIT_W-1:0]      bit_cnt;

    assign line_out = shift[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TX_IDLE;
            shift     <= '1;
            cycle_cnt <= '0;
            bit_cnt   <= '0;
            tx_ack    <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_req) begin
                        shift     <= {1'b1, tx_word, 1'b0}; // stop, data, start
                        cycle_cnt <= '0;
                        bit_cnt   <= '0;
                        state     <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == CNT_W'(`COMMS_BIT_CYCLES - 1)) begin
                        shift   <= {1'b1, shift[FRAME_BITS-1:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                            tx_ack <= 1'b1; // stop bit has gone out
                            state  <= TX_DONE;
                        end
                    end
                end
                default: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // ack only answers a request that is still up
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_ack) |-> $past(tx_req))
        else $error("tx_ack rose without tx_req");

endmodule

`default_nettype wire

// File: hdl/link_ctrl.sv
`default_nettype none

`include "comms_params.svh"

module link_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [1:0]                  player_id,
    input  wire comms_pkg::player_rec_t      local_rec,
    input  wire logic [`COMMS_WORD_BITS-1:0] rx_word,
    input  wire logic                        rx_valid,
    input  wire logic                        tx_ack,
    output logic                             tx_req,
    output logic      [`COMMS_WORD_BITS-1:0] tx_word,
    output logic                             player_wr,
    output logic                             row_wr,
    output logic      [3:0]                  row_idx,
    output logic                             points_wr,
    output logic      [3:0]                  link_status
);
    typedef enum logic [1:0] {
        TX_IDLE     = 2'b00,
        TX_REQ      = 2'b01, // req up, waiting for ack
        TX_RELEASE  = 2'b10, // req down, waiting for ack to drop
        TX_WAIT_ACK = 2'b11  // frame sent, hub ACK pending
    } tx_state_e;

    tx_state_e                   tx_state;
    comms_pkg::pkt_type_e        rx_type;
    logic                        frame_open;
    logic [3:0]                  word_cnt;
    logic                        frame_word, points_slot, spare_slot, ack_seen;
    logic [`COMMS_WORD_BITS-1:0] local_word, last_sent;

    assign rx_type = comms_pkg::pkt_type_e'(rx_word[comms_pkg::TYPE_LSB +: 3]);

    // frame words are raw data, never packets
    assign frame_word  = rx_valid && frame_open;
    assign points_slot = word_cnt == 4'(`COMMS_GRID_ROWS);
    assign spare_slot  = word_cnt == 4'(`COMMS_FRAME_WORDS - 1);
    assign row_wr      = frame_word && !points_slot && !spare_slot;
    assign row_idx     = word_cnt;
    assign points_wr   = frame_word && points_slot;
    assign player_wr   = rx_valid && !frame_open && rx_type == comms_pkg::PKT_PLAYER;
    assign ack_seen    = rx_valid && !frame_open && rx_type == comms_pkg::PKT_ACK;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
            word_cnt   <= '0;
        end else if (rx_valid) begin
            if (!frame_open) begin
                frame_open <= rx_type == comms_pkg::PKT_BOARD_START;
                word_cnt   <= '0;
            end else if (spare_slot) begin
                frame_open <= 1'b0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        local_word = '0; // game state field stays 0 on a secondary
        local_word[comms_pkg::SLOT_LSB +: 2] = player_id;
        local_word[comms_pkg::REC_LSB +: $bits(comms_pkg::player_rec_t)] = local_rec;
        local_word[comms_pkg::TYPE_LSB +: 3] = comms_pkg::PKT_PLAYER;
    end

    assign tx_word = last_sent; // held for the whole handshake

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state  <= TX_IDLE;
            tx_req    <= 1'b0;
            last_sent <= '0;
        end else begin
            case (tx_state)
                TX_IDLE: if (local_word != last_sent) begin
                    last_sent <= local_word;
                    tx_req    <= 1'b1;
                    tx_state  <= TX_REQ;
                end
                TX_REQ: if (tx_ack) begin
                    tx_req   <= 1'b0;
                    tx_state <= TX_RELEASE;
                end
                TX_RELEASE: if (!tx_ack) tx_state <= TX_WAIT_ACK;
                default: if (ack_seen) tx_state <= TX_IDLE;
            endcase
        end
    end

    assign link_status = {tx_req, frame_open, tx_state};

    row_in_range: assert property (@(posedge clk) disable iff (rst)
        row_wr |-> row_idx < 4'(`COMMS_GRID_ROWS))
        else $error("row_idx %0d out of range", row_idx);

    id_not_main: assert property (@(posedge clk) disable iff (rst) player_id != 2'd0)
        else $error("player_id 0 is not supported on a secondary node");

endmodule

`default_nettype wire

// File: hdl/player_table.sv
`default_nettype none

`include "comms_params.svh"

module player_table (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [1:0]                  player_id,
    input  wire comms_pkg::player_rec_t      local_rec,
    input  wire logic [`COMMS_WORD_BITS-1:0] rx_word,
    input  wire logic                        player_wr,
    output comms_pkg::player_rec_t [3:0]     players,
    output logic      [2:0]                  game_state
);
    logic [1:0] rx_slot;

    assign rx_slot = rx_word[comms_pkg::SLOT_LSB +: 2];

    always_ff @(posedge clk) begin
        if (rst) begin
            players    <= '0;
            game_state <= '0;
        end else begin
            if (player_wr && rx_slot != player_id) begin
                players[rx_slot] <= comms_pkg::player_rec_t'(
                    rx_word[comms_pkg::REC_LSB +: $bits(comms_pkg::player_rec_t)]);
            end
            if (player_wr && rx_slot == 2'd0) begin
                game_state <= rx_word[comms_pkg::GAME_LSB +: 3]; // only the main sends it
            end
            players[player_id] <= local_rec; // local slot follows the inputs
        end
    end

endmodule

`default_nettype wire

// File: hdl/board_store.sv
`default_nettype none

`include "comms_params.svh"

module board_store (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [`COMMS_WORD_BITS-1:0]  rx_word,
    input  wire logic                         row_wr,
    input  wire logic [3:0]                   row_idx,
    input  wire logic                         points_wr,
    output comms_pkg::board_t                 grid,
    output logic      [`COMMS_POINT_BITS-1:0] point_total
);
    localparam int CELL_BITS = $bits(comms_pkg::cell_t);

    comms_pkg::row_t new_row;

    // column 0 comes from the top nibble of the word
    always_comb begin
        for (int c = 0; c < `COMMS_GRID_COLS; c++) begin
            new_row[c] = rx_word[`COMMS_WORD_BITS - CELL_BITS * (c + 1) +: CELL_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grid        <= '0;
            point_total <= '0;
        end else begin
            if (row_wr) grid[row_idx] <= new_row;
            if (points_wr) point_total <= rx_word[`COMMS_POINT_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/comms_node.sv
`default_nettype none

`include "comms_params.svh"

module comms_node (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [1:0]                   player_id,   // 1 to 3
    input  wire logic [1:0]                   local_dir,
    input  wire logic [8:0]                   local_loc_x,
    input  wire logic [8:0]                   local_loc_y,
    input  wire logic [3:0]                   local_state,
    input  wire logic                         line_in,
    output logic                              line_out,
    output comms_pkg::player_rec_t [3:0]      players,
    output logic      [2:0]                   game_state,
    output comms_pkg::board_t                 grid,
    output logic      [`COMMS_POINT_BITS-1:0] point_total,
    output logic      [3:0]                   link_status
);
    comms_pkg::player_rec_t      local_rec;
    logic [`COMMS_WORD_BITS-1:0] rx_word, tx_word;
    logic                        rx_valid;
    logic                        tx_req, tx_ack;
    logic                        player_wr, row_wr, points_wr;
    logic [3:0]                  row_idx;

    assign local_rec = {local_dir, local_loc_x, local_loc_y, local_state};

    serial_rx serial_rx_inst (
        .clk      (clk),
        .rst      (rst),
        .line_in  (line_in),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    serial_tx serial_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .tx_req   (tx_req),
        .tx_word  (tx_word),
        .line_out (line_out),
        .tx_ack   (tx_ack)
    );

    link_ctrl link_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .player_id   (player_id),
        .local_rec   (local_rec),
        .rx_word     (rx_word),
        .rx_valid    (rx_valid),
        .tx_ack      (tx_ack),
        .tx_req      (tx_req),
        .tx_word     (tx_word),
        .player_wr   (player_wr),
        .row_wr      (row_wr),
        .row_idx     (row_idx),
        .points_wr   (points_wr),
        .link_status (link_status)
    );

    player_table player_table_inst (
        .clk        (clk),
        .rst        (rst),
        .player_id  (player_id),
        .local_rec  (local_rec),
        .rx_word    (rx_word),
        .player_wr  (player_wr),
        .players    (players),
        .game_state (game_state)
    );

    board_store board_store_inst (
        .clk         (clk),
        .rst         (rst),
        .rx_word     (rx_word),
        .row_wr      (row_wr),
        .row_idx     (row_idx),
        .points_wr   (points_wr),
        .grid        (grid),
        .point_total (point_total)
    );

endmodule

`default_nettype wire

// File: dv/comms_node_tb.sv
`default_nettype none

`include "comms_params.svh"

module comms_node_tb;
    localparam int FRAME_CYCLES = (`COMMS_WORD_BITS + 2) * `COMMS_BIT_CYCLES;
    localparam int N_REMOTE     = 24;
    // hub words, node frames and quiet windows, with margin
    localparam int TOTAL_PACKETS = N_REMOTE + `COMMS_FRAME_WORDS + 17;
    localparam longint WATCHDOG = longint'(TOTAL_PACKETS) * 34 * `COMMS_BIT_CYCLES * 20 * 4;

    logic                                clk, rst, line_in, line_out;
    logic [1:0]                          player_id, local_dir;
    logic [8:0]                          local_loc_x, local_loc_y;
    logic [3:0]                          local_state, link_status;
    comms_pkg::player_rec_t [3:0]        players;
    logic [2:0]                          game_state;
    comms_pkg::board_t                   grid;
    logic [`COMMS_POINT_BITS-1:0]        point_total;

    // reference model
    logic [23:0]                  exp_players [4];
    logic [2:0]                   exp_game;
    logic [3:0]                   exp_cells [`COMMS_GRID_ROWS][`COMMS_GRID_COLS];
    logic [`COMMS_POINT_BITS-1:0] exp_points;
    logic [23:0]                  cur_local;
    logic [31:0]                  sent_words [$]; // frames decoded from line_out
    int                           errors = 0;
    int                           checks = 0;
    int                           tests  = 0;

    comms_node comms_node_inst (
        .clk         (clk),
        .rst         (rst),
        .player_id   (player_id),
        .local_dir   (local_dir),
        .local_loc_x (local_loc_x),
        .local_loc_y (local_loc_y),
        .local_state (local_state),
        .line_in     (line_in),
        .line_out    (line_out),
        .players     (players),
        .game_state  (game_state),
        .grid        (grid),
        .point_total (point_total),
        .link_status (link_status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    function automatic logic [31:0] player_word(input logic [1:0] slot, input logic [23:0] rec,
                                                input logic [2:0] game, input logic [2:0] typ);
        logic [31:0] w;
        w = '0;
        w[comms_pkg::SLOT_LSB +: 2] = slot;
        w[comms_pkg::REC_LSB +: 24] = rec;
        w[comms_pkg::GAME_LSB +: 3] = game;
        w[comms_pkg::TYPE_LSB +: 3] = typ;
        return w;
    endfunction

    // start bit, 32 data bits lsb first, stop bit, then one idle bit
    task automatic send_word(input logic [31:0] w, input logic stop_bit);
        @(negedge clk);
        line_in = 1'b0;
        repeat (`COMMS_BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < 32; i++) begin
            line_in = w[i];
            repeat (`COMMS_BIT_CYCLES) @(negedge clk);
        end
        line_in = stop_bit;
        repeat (`COMMS_BIT_CYCLES) @(negedge clk);
        line_in = 1'b1;
        repeat (`COMMS_BIT_CYCLES) @(negedge clk);
    endtask

    task automatic send_ack();
        send_word(player_word(2'($urandom), 24'($urandom), 3'd0, comms_pkg::PKT_ACK), 1'b1);
    endtask

    task automatic await_frame(output logic [31:0] w, output logic got);
        int waited;
        waited = 0;
        while (sent_words.size() == 0 && waited < 3 * FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        got = sent_words.size() > 0;
        checks++;
        assert (got)
        else report_failure("no frame appeared on line_out in time");
        w = got ? sent_words.pop_front() : '0;
    endtask

    task automatic expect_quiet(input int frames);
        repeat (frames * FRAME_CYCLES + `COMMS_BIT_CYCLES) @(negedge clk);
        checks++;
        assert (sent_words.size() == 0)
        else begin
            report_failure($sformatf("%0d unexpected frame(s) on line_out", sent_words.size()));
            sent_words.delete();
        end
    endtask

    task automatic drive_local(input logic [23:0] rec);
        @(negedge clk);
        {local_dir, local_loc_x, local_loc_y, local_state} = rec;
        cur_local = rec;
        exp_players[player_id] = rec;
    endtask

    task automatic check_frame(input logic [31:0] w);
        compare_value("frame slot", player_id, w[comms_pkg::SLOT_LSB +: 2]);
        compare_value("frame record", cur_local, w[comms_pkg::REC_LSB +: 24]);
        compare_value("frame game state", 3'd0, w[comms_pkg::GAME_LSB +: 3]);
        compare_value("frame type", comms_pkg::PKT_PLAYER, w[comms_pkg::TYPE_LSB +: 3]);
    endtask

    task automatic check_table();
        for (int i = 0; i < 4; i++) begin
            compare_value($sformatf("players[%0d]", i), exp_players[i], players[i]);
        end
        compare_value("game_state", exp_game, game_state);
    endtask

    task automatic check_board();
        for (int r = 0; r < `COMMS_GRID_ROWS; r++) begin
            for (int c = 0; c < `COMMS_GRID_COLS; c++) begin
                compare_value($sformatf("grid[%0d][%0d]", r, c), exp_cells[r][c], grid[r][c]);
            end
        end
        compare_value("point_total", exp_points, point_total);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %0d (%s) done with %0d error(s)", tests, name, errors - errors_before);
    endtask

    // hub side receiver, sampling line_out mid-bit on falling edges
    initial begin : frame_monitor
        logic [31:0] bits;
        forever begin
            @(negedge clk);
            if (!rst && !line_out) begin
                repeat (`COMMS_BIT_CYCLES / 2 - 1) @(negedge clk);
                assert (!line_out)
                else report_failure("start bit on line_out did not last to mid-bit");
                for (int i = 0; i < 32; i++) begin
                    repeat (`COMMS_BIT_CYCLES) @(negedge clk);
                    bits[i] = line_out;
                end
                repeat (`COMMS_BIT_CYCLES) @(negedge clk);
                assert (line_out)
                else report_failure("frame on line_out ended with a low stop bit");
                if (line_out) sent_words.push_back(bits);
            end
        end
    end

    initial begin : main
        logic [31:0] w, words [`COMMS_FRAME_WORDS];
        logic [23:0] rec;
        logic [2:0]  game;
        logic [1:0]  slot;
        logic        got;
        int          mark;

        w = $urandom(32'h518e0f0a);
        rst = 1'b1;
        line_in = 1'b1;
        player_id = 2'($urandom_range(3, 1));
        {local_dir, local_loc_x, local_loc_y, local_state} = '0;
        cur_local = '0;
        exp_game = '0;
        exp_points = '0;
        for (int i = 0; i < 4; i++) exp_players[i] = '0;
        for (int r = 0; r < `COMMS_GRID_ROWS; r++)
            for (int c = 0; c < `COMMS_GRID_COLS; c++) exp_cells[r][c] = '0;

        // reset, then the one frame every node sends after reset
        mark = errors;
        repeat (5) @(posedge clk);
        @(negedge clk);
        compare_value("line_out", 1'b1, line_out);
        compare_value("link_status", 4'h0, link_status);
        check_table();
        check_board();
        rst = 1'b0;
        await_frame(w, got);
        if (got) check_frame(w);
        send_ack();
        finish_test("reset", mark);

        mark = errors;
        for (int n = 0; n < N_REMOTE; n++) begin
            slot = 2'($urandom);
            rec  = 24'($urandom);
            game = 3'($urandom);
            if (slot != player_id) exp_players[slot] = rec;
            if (slot == 2'd0) exp_game = game;
            send_word(player_word(slot, rec, game, comms_pkg::PKT_PLAYER), 1'b1);
            check_table();
        end
        finish_test("remote player packets", mark);

        mark = errors;
        send_word(player_word(2'($urandom), 24'($urandom), 3'($urandom),
                              comms_pkg::PKT_BOARD_START), 1'b1);
        for (int i = 0; i < `COMMS_FRAME_WORDS; i++) begin
            words[i] = $urandom;
            if (i % 2 == 0) words[i][comms_pkg::TYPE_LSB +: 3] = comms_pkg::PKT_PLAYER;
            if (i == 5) words[i][comms_pkg::TYPE_LSB +: 3] = comms_pkg::PKT_ACK;
            send_word(words[i], 1'b1);
        end
        for (int r = 0; r < `COMMS_GRID_ROWS; r++)
            for (int c = 0; c < `COMMS_GRID_COLS; c++)
                exp_cells[r][c] = words[r][31 - 4 * c -: 4]; // column 0 at the top
        exp_points = words[`COMMS_GRID_ROWS][`COMMS_POINT_BITS-1:0];
        check_board();
        check_table();
        compare_value("link_status[2]", 1'b0, link_status[2]);
        finish_test("board frame", mark);

        mark = errors;
        do rec = 24'($urandom); while (rec == cur_local);
        drive_local(rec);
        @(negedge clk);
        compare_value("link_status[3]", 1'b1, link_status[3]); // request is up
        await_frame(w, got);
        if (got) check_frame(w);
        expect_quiet(2);
        finish_test("transmit", mark);

        // no ACK yet, so these changes must wait
        mark = errors;
        repeat (3) begin
            do rec = 24'($urandom); while (rec == cur_local);
            drive_local(rec);
            repeat (20) @(negedge clk);
        end
        expect_quiet(2);
        compare_value("link_status[3:2]", 2'b00, link_status[3:2]);
        checks++;
        assert (link_status[1:0] != 2'd0)
        else report_failure("link_status shows an idle transmit FSM while an ACK is pending");
        send_ack();
        await_frame(w, got);
        if (got) check_frame(w);
        send_ack();
        expect_quiet(2);
        check_table();
        finish_test("back-pressure", mark);

        mark = errors;
        do rec = 24'($urandom); while (rec == exp_players[0]);
        w = player_word(2'd0, rec, exp_game + 3'd1, comms_pkg::PKT_PLAYER);
        send_word(w, 1'b0);
        check_table();
        check_board();
        compare_value("link_status", 4'h0, link_status);
        expect_quiet(1);
        compare_value("line_out", 1'b1, line_out);
        // same word with a good stop bit must still get through
        send_word(w, 1'b1);
        exp_players[0] = rec;
        exp_game = exp_game + 3'd1;
        check_table();
        finish_test("framing errors", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/comms_pkg.sv
link/serial_rx.sv
link/serial_tx.sv
hdl/link_ctrl.sv
hdl/player_table.sv
hdl/board_store.sv
hdl/comms_node.sv
dv/comms_node_tb.sv
